/* source/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Instruction field widths.
`define OPCODE_W 6
`define FUNC_W   6

// Width of the ALU operation select.
`define ALUSEL_W 4

`endif

/* source/isa_pkg.sv */
`default_nettype none

`include "ctrl_params.svh"

package isa_pkg;

        localparam logic [`OPCODE_W-1:0] OP_SPECIAL = 6'b000000;
        localparam logic [`OPCODE_W-1:0] OP_ADDI    = 6'b001000;
        localparam logic [`OPCODE_W-1:0] OP_ADDIU   = 6'b001001;
        localparam logic [`OPCODE_W-1:0] OP_ANDI    = 6'b001100;
        localparam logic [`OPCODE_W-1:0] OP_ORI     = 6'b001101;
        localparam logic [`OPCODE_W-1:0] OP_XORI    = 6'b001110;
        localparam logic [`OPCODE_W-1:0] OP_SLTI    = 6'b001010;
        localparam logic [`OPCODE_W-1:0] OP_SLTIU   = 6'b001011;
        localparam logic [`OPCODE_W-1:0] OP_LUI     = 6'b001111;
        // This core places lw at 010011 rather than the usual MIPS slot.
        localparam logic [`OPCODE_W-1:0] OP_LW      = 6'b010011;
        localparam logic [`OPCODE_W-1:0] OP_SW      = 6'b101011;
        localparam logic [`OPCODE_W-1:0] OP_LB      = 6'b100000;
        localparam logic [`OPCODE_W-1:0] OP_SB      = 6'b101000;
        localparam logic [`OPCODE_W-1:0] OP_LH      = 6'b100001;
        localparam logic [`OPCODE_W-1:0] OP_SH      = 6'b101001;
        localparam logic [`OPCODE_W-1:0] OP_J       = 6'b000010;
        localparam logic [`OPCODE_W-1:0] OP_BEQ     = 6'b000100;
        localparam logic [`OPCODE_W-1:0] OP_BNE     = 6'b000101;
        localparam logic [`OPCODE_W-1:0] OP_BLEZ    = 6'b000110;
        localparam logic [`OPCODE_W-1:0] OP_BGTZ    = 6'b000111;

        // Function codes are only meaningful under OP_SPECIAL.
        localparam logic [`FUNC_W-1:0] FN_ADD  = 6'b100000;
        localparam logic [`FUNC_W-1:0] FN_ADDU = 6'b100001;
        localparam logic [`FUNC_W-1:0] FN_SUB  = 6'b100010;
        localparam logic [`FUNC_W-1:0] FN_SUBU = 6'b100011;
        localparam logic [`FUNC_W-1:0] FN_AND  = 6'b100100;
        localparam logic [`FUNC_W-1:0] FN_OR   = 6'b100101;
        localparam logic [`FUNC_W-1:0] FN_XOR  = 6'b100110;
        localparam logic [`FUNC_W-1:0] FN_NOR  = 6'b100111;
        localparam logic [`FUNC_W-1:0] FN_SLT  = 6'b101010;
        localparam logic [`FUNC_W-1:0] FN_SLTU = 6'b101011;
        localparam logic [`FUNC_W-1:0] FN_SLL  = 6'b000000;
        localparam logic [`FUNC_W-1:0] FN_SRL  = 6'b000010;
        localparam logic [`FUNC_W-1:0] FN_SRA  = 6'b000011;
        localparam logic [`FUNC_W-1:0] FN_SLLV = 6'b000100;
        localparam logic [`FUNC_W-1:0] FN_SRLV = 6'b000110;

        typedef enum logic [5:0] {
                CLS_RESERVED = 6'd0,
                CLS_ADD, CLS_ADDU, CLS_SUB, CLS_SUBU,
                CLS_AND, CLS_OR, CLS_XOR, CLS_NOR,
                CLS_SLT, CLS_SLTU,
                CLS_SLL, CLS_SRL, CLS_SRA, CLS_SLLV, CLS_SRLV,
                CLS_ADDI, CLS_ADDIU, CLS_ANDI, CLS_ORI, CLS_XORI,
                CLS_SLTI, CLS_SLTIU, CLS_LUI,
                CLS_LW, CLS_SW, CLS_LB, CLS_SB, CLS_LH, CLS_SH,
                CLS_J, CLS_BEQ, CLS_BNE, CLS_BLEZ, CLS_BGTZ
        } inst_class_t;

endpackage

`default_nettype wire

/* source/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_params.svh"

package ctrl_pkg;

        typedef enum logic [2:0] {
                BR_NONE = 3'd0,
                BR_J,
                BR_BEQ,
                BR_BNE,
                BR_BLEZ,
                BR_BGTZ
        } branch_t;

        typedef enum logic [1:0] {
                A_NONE = 2'd0,
                A_RS,
                A_SHAMT,
                A_CONST16
        } alu_a_t;

        typedef enum logic {
                B_RT  = 1'b0,
                B_IMM = 1'b1
        } alu_b_t;

        typedef enum logic [`ALUSEL_W-1:0] {
                OP_NONE = '0,
                ADD, SUB, AND, OR, XOR, NOR,
                LT, LTU, SL, SRL, SRA
        } alu_op_t;

        typedef enum logic [1:0] {
                LEN_NONE = 2'd0,
                LEN_BYTE,
                LEN_HALF,
                LEN_WORD
        } mem_len_t;

        typedef enum logic {
                WA_RD = 1'b0,
                WA_RT = 1'b1
        } wa_sel_t;

        typedef enum logic [1:0] {
                WD_NONE = 2'd0,
                WD_ALU,
                WD_MEM
        } wd_sel_t;

        typedef struct packed {
                branch_t branch;
                alu_a_t  alu_a;
                alu_b_t  alu_b;
                alu_op_t alu_op;
        } exec_ctrl_t;

        typedef struct packed {
                logic     dmem_we;
                mem_len_t mem_len;
        } mem_ctrl_t;

        typedef struct packed {
                wa_sel_t wa_sel;
                wd_sel_t wd_sel;
                logic    reg_we;
        } wb_ctrl_t;

        typedef struct packed {
                exec_ctrl_t exec;
                mem_ctrl_t  mem;
                wb_ctrl_t   wb;
        } ctrl_word_t;

endpackage

`default_nettype wire

/* source/inst_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module inst_classifier (
        input  wire [`OPCODE_W-1:0]  opcode,
        input  wire [`FUNC_W-1:0]    func,
        output isa_pkg::inst_class_t cls
);

        isa_pkg::inst_class_t fn_cls;

        // SPECIAL instructions are told apart by the function field alone.
        always_comb begin
                case (func)
                        isa_pkg::FN_ADD:  fn_cls = isa_pkg::CLS_ADD;
                        isa_pkg::FN_ADDU: fn_cls = isa_pkg::CLS_ADDU;
                        isa_pkg::FN_SUB:  fn_cls = isa_pkg::CLS_SUB;
                        isa_pkg::FN_SUBU: fn_cls = isa_pkg::CLS_SUBU;
                        isa_pkg::FN_AND:  fn_cls = isa_pkg::CLS_AND;
                        isa_pkg::FN_OR:   fn_cls = isa_pkg::CLS_OR;
                        isa_pkg::FN_XOR:  fn_cls = isa_pkg::CLS_XOR;
                        isa_pkg::FN_NOR:  fn_cls = isa_pkg::CLS_NOR;
                        isa_pkg::FN_SLT:  fn_cls = isa_pkg::CLS_SLT;
                        isa_pkg::FN_SLTU: fn_cls = isa_pkg::CLS_SLTU;
                        isa_pkg::FN_SLL:  fn_cls = isa_pkg::CLS_SLL;
                        isa_pkg::FN_SRL:  fn_cls = isa_pkg::CLS_SRL;
                        isa_pkg::FN_SRA:  fn_cls = isa_pkg::CLS_SRA;
                        isa_pkg::FN_SLLV: fn_cls = isa_pkg::CLS_SLLV;
                        isa_pkg::FN_SRLV: fn_cls = isa_pkg::CLS_SRLV;
                        default:          fn_cls = isa_pkg::CLS_RESERVED;
                endcase
        end

        always_comb begin
                case (opcode)
                        isa_pkg::OP_SPECIAL: cls = fn_cls;
                        isa_pkg::OP_ADDI:    cls = isa_pkg::CLS_ADDI;
                        isa_pkg::OP_ADDIU:   cls = isa_pkg::CLS_ADDIU;
                        isa_pkg::OP_ANDI:    cls = isa_pkg::CLS_ANDI;
                        isa_pkg::OP_ORI:     cls = isa_pkg::CLS_ORI;
                        isa_pkg::OP_XORI:    cls = isa_pkg::CLS_XORI;
                        isa_pkg::OP_SLTI:    cls = isa_pkg::CLS_SLTI;
                        isa_pkg::OP_SLTIU:   cls = isa_pkg::CLS_SLTIU;
                        isa_pkg::OP_LUI:     cls = isa_pkg::CLS_LUI;
                        isa_pkg::OP_LW:      cls = isa_pkg::CLS_LW;
                        isa_pkg::OP_SW:      cls = isa_pkg::CLS_SW;
                        isa_pkg::OP_LB:      cls = isa_pkg::CLS_LB;
                        isa_pkg::OP_SB:      cls = isa_pkg::CLS_SB;
                        isa_pkg::OP_LH:      cls = isa_pkg::CLS_LH;
                        isa_pkg::OP_SH:      cls = isa_pkg::CLS_SH;
                        isa_pkg::OP_J:       cls = isa_pkg::CLS_J;
                        isa_pkg::OP_BEQ:     cls = isa_pkg::CLS_BEQ;
                        isa_pkg::OP_BNE:     cls = isa_pkg::CLS_BNE;
                        isa_pkg::OP_BLEZ:    cls = isa_pkg::CLS_BLEZ;
                        isa_pkg::OP_BGTZ:    cls = isa_pkg::CLS_BGTZ;
                        // Multiply, divide and HI/LO opcodes land here too.
                        default:             cls = isa_pkg::CLS_RESERVED;
                endcase
        end

endmodule

`default_nettype wire

/* source/exec_ctrl_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl_decoder (
        input  wire                       clk,
        input  wire                       rst_n,
        input  wire isa_pkg::inst_class_t cls,
        output ctrl_pkg::exec_ctrl_t      exec
);

        ctrl_pkg::exec_ctrl_t exec_d;

        always_comb begin
                exec_d = '0;

                case (cls)
                        isa_pkg::CLS_ADD, isa_pkg::CLS_ADDU, isa_pkg::CLS_ADDI,
                        isa_pkg::CLS_ADDIU, isa_pkg::CLS_LW, isa_pkg::CLS_SW,
                        isa_pkg::CLS_LB, isa_pkg::CLS_SB, isa_pkg::CLS_LH,
                        isa_pkg::CLS_SH:
                                exec_d.alu_op = ctrl_pkg::ADD;
                        isa_pkg::CLS_SUB, isa_pkg::CLS_SUBU:
                                exec_d.alu_op = ctrl_pkg::SUB;
                        isa_pkg::CLS_AND, isa_pkg::CLS_ANDI: exec_d.alu_op = ctrl_pkg::AND;
                        isa_pkg::CLS_OR, isa_pkg::CLS_ORI:   exec_d.alu_op = ctrl_pkg::OR;
                        isa_pkg::CLS_XOR, isa_pkg::CLS_XORI: exec_d.alu_op = ctrl_pkg::XOR;
                        isa_pkg::CLS_NOR:                    exec_d.alu_op = ctrl_pkg::NOR;
                        isa_pkg::CLS_SLT, isa_pkg::CLS_SLTI: exec_d.alu_op = ctrl_pkg::LT;
                        isa_pkg::CLS_SLTU, isa_pkg::CLS_SLTIU:
                                exec_d.alu_op = ctrl_pkg::LTU;
                        // lui is a left shift of the immediate by a constant 16.
                        isa_pkg::CLS_SLL, isa_pkg::CLS_SLLV, isa_pkg::CLS_LUI:
                                exec_d.alu_op = ctrl_pkg::SL;
                        isa_pkg::CLS_SRL, isa_pkg::CLS_SRLV:
                                exec_d.alu_op = ctrl_pkg::SRL;
                        isa_pkg::CLS_SRA:                    exec_d.alu_op = ctrl_pkg::SRA;
                        default: ;
                endcase

                case (cls)
                        isa_pkg::CLS_ADD, isa_pkg::CLS_ADDU, isa_pkg::CLS_SUB,
                        isa_pkg::CLS_SUBU, isa_pkg::CLS_AND, isa_pkg::CLS_OR,
                        isa_pkg::CLS_XOR, isa_pkg::CLS_NOR, isa_pkg::CLS_SLT,
                        isa_pkg::CLS_SLTU, isa_pkg::CLS_SLLV, isa_pkg::CLS_SRLV: begin
                                exec_d.alu_a = ctrl_pkg::A_RS;
                                exec_d.alu_b = ctrl_pkg::B_RT;
                        end
                        isa_pkg::CLS_SLL, isa_pkg::CLS_SRL, isa_pkg::CLS_SRA: begin
                                exec_d.alu_a = ctrl_pkg::A_SHAMT;
                                exec_d.alu_b = ctrl_pkg::B_RT;
                        end
                        isa_pkg::CLS_ADDI, isa_pkg::CLS_ADDIU, isa_pkg::CLS_ANDI,
                        isa_pkg::CLS_ORI, isa_pkg::CLS_XORI, isa_pkg::CLS_SLTI,
                        isa_pkg::CLS_SLTIU, isa_pkg::CLS_LW, isa_pkg::CLS_SW,
                        isa_pkg::CLS_LB, isa_pkg::CLS_SB, isa_pkg::CLS_LH,
                        isa_pkg::CLS_SH: begin
                                exec_d.alu_a = ctrl_pkg::A_RS;
                                exec_d.alu_b = ctrl_pkg::B_IMM;
                        end
                        isa_pkg::CLS_LUI: begin
                                exec_d.alu_a = ctrl_pkg::A_CONST16;
                                exec_d.alu_b = ctrl_pkg::B_IMM;
                        end
                        default: ;
                endcase

                case (cls)
                        isa_pkg::CLS_J:    exec_d.branch = ctrl_pkg::BR_J;
                        isa_pkg::CLS_BEQ:  exec_d.branch = ctrl_pkg::BR_BEQ;
                        isa_pkg::CLS_BNE:  exec_d.branch = ctrl_pkg::BR_BNE;
                        isa_pkg::CLS_BLEZ: exec_d.branch = ctrl_pkg::BR_BLEZ;
                        isa_pkg::CLS_BGTZ: exec_d.branch = ctrl_pkg::BR_BGTZ;
                        default: ;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        exec <= '0;
                end else begin
                        exec <= exec_d;
                end
        end

        // Branch compares are resolved outside the ALU, so it must stay idle.
        a_branch_alu_idle: assert property (@(posedge clk) disable iff (!rst_n)
                exec.branch != ctrl_pkg::BR_NONE |-> exec.alu_op == ctrl_pkg::OP_NONE);

        a_shamt_is_shift: assert property (@(posedge clk) disable iff (!rst_n)
                exec.alu_a == ctrl_pkg::A_SHAMT |->
                        exec.alu_op inside {ctrl_pkg::SL, ctrl_pkg::SRL, ctrl_pkg::SRA});

endmodule

`default_nettype wire

/* source/memwb_ctrl_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module memwb_ctrl_decoder (
        input  wire                       clk,
        input  wire                       rst_n,
        input  wire isa_pkg::inst_class_t cls,
        output ctrl_pkg::mem_ctrl_t       mem,
        output ctrl_pkg::wb_ctrl_t        wb
);

        ctrl_pkg::mem_ctrl_t mem_d;
        ctrl_pkg::wb_ctrl_t  wb_d;

        always_comb begin
                mem_d = '0;
                wb_d  = '0;

                case (cls)
                        isa_pkg::CLS_LB, isa_pkg::CLS_SB: mem_d.mem_len = ctrl_pkg::LEN_BYTE;
                        isa_pkg::CLS_LH, isa_pkg::CLS_SH: mem_d.mem_len = ctrl_pkg::LEN_HALF;
                        isa_pkg::CLS_LW, isa_pkg::CLS_SW: mem_d.mem_len = ctrl_pkg::LEN_WORD;
                        default: ;
                endcase

                case (cls)
                        isa_pkg::CLS_SB, isa_pkg::CLS_SH, isa_pkg::CLS_SW:
                                mem_d.dmem_we = 1'b1;
                        isa_pkg::CLS_LB, isa_pkg::CLS_LH, isa_pkg::CLS_LW: begin
                                wb_d.wa_sel = ctrl_pkg::WA_RT;
                                wb_d.wd_sel = ctrl_pkg::WD_MEM;
                                wb_d.reg_we = 1'b1;
                        end
                        isa_pkg::CLS_ADD, isa_pkg::CLS_ADDU, isa_pkg::CLS_SUB,
                        isa_pkg::CLS_SUBU, isa_pkg::CLS_AND, isa_pkg::CLS_OR,
                        isa_pkg::CLS_XOR, isa_pkg::CLS_NOR, isa_pkg::CLS_SLT,
                        isa_pkg::CLS_SLTU, isa_pkg::CLS_SLL, isa_pkg::CLS_SRL,
                        isa_pkg::CLS_SRA, isa_pkg::CLS_SLLV, isa_pkg::CLS_SRLV: begin
                                wb_d.wa_sel = ctrl_pkg::WA_RD;
                                wb_d.wd_sel = ctrl_pkg::WD_ALU;
                                wb_d.reg_we = 1'b1;
                        end
                        isa_pkg::CLS_ADDI, isa_pkg::CLS_ADDIU, isa_pkg::CLS_ANDI,
                        isa_pkg::CLS_ORI, isa_pkg::CLS_XORI, isa_pkg::CLS_SLTI,
                        isa_pkg::CLS_SLTIU, isa_pkg::CLS_LUI: begin
                                wb_d.wa_sel = ctrl_pkg::WA_RT;
                                wb_d.wd_sel = ctrl_pkg::WD_ALU;
                                wb_d.reg_we = 1'b1;
                        end
                        // Jumps, branches and reserved codes write nothing.
                        default: ;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        mem <= '0;
                        wb  <= '0;
                end else begin
                        mem <= mem_d;
                        wb  <= wb_d;
                end
        end

        // No instruction in this ISA both stores and writes a register.
        a_store_no_regwrite: assert property (@(posedge clk) disable iff (!rst_n)
                !(mem.dmem_we && wb.reg_we));

        a_store_has_len: assert property (@(posedge clk) disable iff (!rst_n)
                mem.dmem_we |-> mem.mem_len != ctrl_pkg::LEN_NONE);

endmodule

`default_nettype wire

/* source/ctrl_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module ctrl_decoder (
        input  wire                  clk,
        input  wire                  rst_n,
        input  wire [`OPCODE_W-1:0]  opcode,
        input  wire [`FUNC_W-1:0]    func,
        output ctrl_pkg::ctrl_word_t ctrl
);

        isa_pkg::inst_class_t cls;
        ctrl_pkg::exec_ctrl_t exec;
        ctrl_pkg::mem_ctrl_t  mem;
        ctrl_pkg::wb_ctrl_t   wb;

        inst_classifier i_inst_classifier (
                .opcode (opcode),
                .func   (func),
                .cls    (cls)
        );

        exec_ctrl_decoder i_exec_ctrl_decoder (
                .clk   (clk),
                .rst_n (rst_n),
                .cls   (cls),
                .exec  (exec)
        );

        memwb_ctrl_decoder i_memwb_ctrl_decoder (
                .clk   (clk),
                .rst_n (rst_n),
                .cls   (cls),
                .mem   (mem),
                .wb    (wb)
        );

        assign ctrl = {exec, mem, wb};

endmodule

`default_nettype wire

/* tb/ctrl_decoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module ctrl_decoder_tb;

        localparam int RESET_CYCLES  = 10;
        localparam int N_REG         = 400;
        localparam int N_IMM         = 400;
        localparam int N_MEM         = 400;
        localparam int N_BRANCH      = 300;
        localparam int N_RANDOM      = 600;
        localparam int TOTAL_VECTORS = RESET_CYCLES + N_REG + N_IMM + N_MEM + N_BRANCH + N_RANDOM;
        localparam int CYCLE_LIMIT   = 2 * TOTAL_VECTORS + 100;

        logic                 clk;
        logic                 rst_n;
        logic [`OPCODE_W-1:0] opcode;
        logic [`FUNC_W-1:0]   func;
        ctrl_pkg::ctrl_word_t ctrl;

        ctrl_pkg::ctrl_word_t expected;
        logic                 pending;
        int                   check_count = 0;
        int                   error_count = 0;
        int                   test_errors = 0;
        int                   cycle_count = 0;

        ctrl_decoder i_ctrl_decoder (
                .clk    (clk),
                .rst_n  (rst_n),
                .opcode (opcode),
                .func   (func),
                .ctrl   (ctrl)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= CYCLE_LIMIT) begin
                        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("Verification failed");
                        $finish;
                end
        end

        function automatic logic [5:0] random_field();
                logic [31:0] r;
                r = $urandom();
                return r[5:0];
        endfunction

        // Maps a SPECIAL function code to its ALU operation, or to OP_NONE if it is not kept.
        function automatic ctrl_pkg::alu_op_t reg_alu_op(input logic [`FUNC_W-1:0] fn);
                case (fn)
                        isa_pkg::FN_ADD, isa_pkg::FN_ADDU: return ctrl_pkg::ADD;
                        isa_pkg::FN_SUB, isa_pkg::FN_SUBU: return ctrl_pkg::SUB;
                        isa_pkg::FN_AND:                   return ctrl_pkg::AND;
                        isa_pkg::FN_OR:                    return ctrl_pkg::OR;
                        isa_pkg::FN_XOR:                   return ctrl_pkg::XOR;
                        isa_pkg::FN_NOR:                   return ctrl_pkg::NOR;
                        isa_pkg::FN_SLT:                   return ctrl_pkg::LT;
                        isa_pkg::FN_SLTU:                  return ctrl_pkg::LTU;
                        isa_pkg::FN_SLL, isa_pkg::FN_SLLV: return ctrl_pkg::SL;
                        isa_pkg::FN_SRL, isa_pkg::FN_SRLV: return ctrl_pkg::SRL;
                        isa_pkg::FN_SRA:                   return ctrl_pkg::SRA;
                        default:                           return ctrl_pkg::OP_NONE;
                endcase
        endfunction

        function automatic ctrl_pkg::alu_op_t imm_alu_op(input logic [`OPCODE_W-1:0] op);
                case (op)
                        isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU: return ctrl_pkg::ADD;
                        isa_pkg::OP_ANDI:                    return ctrl_pkg::AND;
                        isa_pkg::OP_ORI:                     return ctrl_pkg::OR;
                        isa_pkg::OP_XORI:                    return ctrl_pkg::XOR;
                        isa_pkg::OP_SLTI:                    return ctrl_pkg::LT;
                        isa_pkg::OP_SLTIU:                   return ctrl_pkg::LTU;
                        isa_pkg::OP_LUI:                     return ctrl_pkg::SL;
                        default:                             return ctrl_pkg::OP_NONE;
                endcase
        endfunction

        function automatic ctrl_pkg::mem_len_t access_len(input logic [`OPCODE_W-1:0] op);
                case (op)
                        isa_pkg::OP_LB, isa_pkg::OP_SB: return ctrl_pkg::LEN_BYTE;
                        isa_pkg::OP_LH, isa_pkg::OP_SH: return ctrl_pkg::LEN_HALF;
                        isa_pkg::OP_LW, isa_pkg::OP_SW: return ctrl_pkg::LEN_WORD;
                        default:                        return ctrl_pkg::LEN_NONE;
                endcase
        endfunction

        function automatic ctrl_pkg::branch_t branch_of(input logic [`OPCODE_W-1:0] op);
                case (op)
                        isa_pkg::OP_J:    return ctrl_pkg::BR_J;
                        isa_pkg::OP_BEQ:  return ctrl_pkg::BR_BEQ;
                        isa_pkg::OP_BNE:  return ctrl_pkg::BR_BNE;
                        isa_pkg::OP_BLEZ: return ctrl_pkg::BR_BLEZ;
                        isa_pkg::OP_BGTZ: return ctrl_pkg::BR_BGTZ;
                        default:          return ctrl_pkg::BR_NONE;
                endcase
        endfunction

        // The reference model builds the full control word one family at a time.
        function automatic ctrl_pkg::ctrl_word_t expected_ctrl(input logic [`OPCODE_W-1:0] op,
                                                               input logic [`FUNC_W-1:0] fn);
                ctrl_pkg::ctrl_word_t w;
                w = '0;
                if (op == isa_pkg::OP_SPECIAL) begin
                        w.exec.alu_op = reg_alu_op(fn);
                        if (w.exec.alu_op != ctrl_pkg::OP_NONE) begin
                                w.exec.alu_a = ctrl_pkg::A_RS;
                                if (fn == isa_pkg::FN_SLL || fn == isa_pkg::FN_SRL ||
                                    fn == isa_pkg::FN_SRA) begin
                                        w.exec.alu_a = ctrl_pkg::A_SHAMT;
                                end
                                w.exec.alu_b = ctrl_pkg::B_RT;
                                w.wb.wa_sel  = ctrl_pkg::WA_RD;
                                w.wb.wd_sel  = ctrl_pkg::WD_ALU;
                                w.wb.reg_we  = 1'b1;
                        end
                end else begin
                        w.exec.alu_op = imm_alu_op(op);
                        if (w.exec.alu_op != ctrl_pkg::OP_NONE) begin
                                w.exec.alu_a = ctrl_pkg::A_RS;
                                if (op == isa_pkg::OP_LUI) begin
                                        w.exec.alu_a = ctrl_pkg::A_CONST16;
                                end
                                w.exec.alu_b = ctrl_pkg::B_IMM;
                                w.wb.wa_sel  = ctrl_pkg::WA_RT;
                                w.wb.wd_sel  = ctrl_pkg::WD_ALU;
                                w.wb.reg_we  = 1'b1;
                        end
                        w.mem.mem_len = access_len(op);
                        if (w.mem.mem_len != ctrl_pkg::LEN_NONE) begin
                                w.exec.alu_a  = ctrl_pkg::A_RS;
                                w.exec.alu_b  = ctrl_pkg::B_IMM;
                                w.exec.alu_op = ctrl_pkg::ADD;
                                if (op == isa_pkg::OP_SW || op == isa_pkg::OP_SB ||
                                    op == isa_pkg::OP_SH) begin
                                        w.mem.dmem_we = 1'b1;
                                end else begin
                                        w.wb.wa_sel = ctrl_pkg::WA_RT;
                                        w.wb.wd_sel = ctrl_pkg::WD_MEM;
                                        w.wb.reg_we = 1'b1;
                                end
                        end
                        w.exec.branch = branch_of(op);
                end
                return w;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                check_count++;
                if (got !== exp) begin
                        error_count++;
                        test_errors++;
                        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
                end
        endtask

        task automatic check_word(input ctrl_pkg::ctrl_word_t exp);
                check_value("ctrl.exec.branch", 32'(ctrl.exec.branch), 32'(exp.exec.branch));
                check_value("ctrl.exec.alu_a", 32'(ctrl.exec.alu_a), 32'(exp.exec.alu_a));
                check_value("ctrl.exec.alu_b", 32'(ctrl.exec.alu_b), 32'(exp.exec.alu_b));
                check_value("ctrl.exec.alu_op", 32'(ctrl.exec.alu_op), 32'(exp.exec.alu_op));
                check_value("ctrl.mem.dmem_we", 32'(ctrl.mem.dmem_we), 32'(exp.mem.dmem_we));
                check_value("ctrl.mem.mem_len", 32'(ctrl.mem.mem_len), 32'(exp.mem.mem_len));
                check_value("ctrl.wb.wa_sel", 32'(ctrl.wb.wa_sel), 32'(exp.wb.wa_sel));
                check_value("ctrl.wb.wd_sel", 32'(ctrl.wb.wd_sel), 32'(exp.wb.wd_sel));
                check_value("ctrl.wb.reg_we", 32'(ctrl.wb.reg_we), 32'(exp.wb.reg_we));
        endtask

        // The word driven on one falling edge is checked on the next one.
        task automatic drive_vector(input logic [`OPCODE_W-1:0] op, input logic [`FUNC_W-1:0] fn);
                @(negedge clk);
                if (pending) begin
                        check_word(expected);
                end
                opcode   = op;
                func     = fn;
                expected = expected_ctrl(op, fn);
                pending  = 1'b1;
        endtask

        task automatic report_test(input string name, input int vectors);
                if (pending) begin
                        @(negedge clk);
                        check_word(expected);
                        pending = 1'b0;
                end
                $display("test %s: %0d vectors, %0d errors", name, vectors, test_errors);
                test_errors = 0;
        endtask

        initial begin
                int                   i;
                logic [`OPCODE_W-1:0] op;
                logic [`FUNC_W-1:0]   fn;

                rst_n   = 1'b0;
                opcode  = '0;
                func    = '0;
                pending = 1'b0;
                void'($urandom(32'h9a9f0661));

                // Reset must hold the word at zero whatever instruction is presented.
                for (i = 0; i < RESET_CYCLES; i++) begin
                        @(negedge clk);
                        check_word('0);
                        opcode = random_field();
                        func   = random_field();
                end
                rst_n    = 1'b1;
                expected = expected_ctrl(opcode, func);
                pending  = 1'b1;
                report_test("reset", RESET_CYCLES);

                for (i = 0; i < N_REG; i++) begin
                        do begin
                                fn = random_field();
                        end while (reg_alu_op(fn) == ctrl_pkg::OP_NONE);
                        drive_vector(isa_pkg::OP_SPECIAL, fn);
                end
                report_test("register_alu", N_REG);

                for (i = 0; i < N_IMM; i++) begin
                        do begin
                                op = random_field();
                        end while (imm_alu_op(op) == ctrl_pkg::OP_NONE);
                        drive_vector(op, random_field());
                end
                report_test("immediate_alu", N_IMM);

                for (i = 0; i < N_MEM; i++) begin
                        do begin
                                op = random_field();
                        end while (access_len(op) == ctrl_pkg::LEN_NONE);
                        drive_vector(op, random_field());
                end
                report_test("load_store", N_MEM);

                for (i = 0; i < N_BRANCH; i++) begin
                        do begin
                                op = random_field();
                        end while (branch_of(op) == ctrl_pkg::BR_NONE);
                        drive_vector(op, random_field());
                end
                report_test("jump_branch", N_BRANCH);

                // SPECIAL is favoured so that the dropped multiply and divide codes show up.
                for (i = 0; i < N_RANDOM; i++) begin
                        op = random_field();
                        if ($urandom % 4 == 0) begin
                                op = isa_pkg::OP_SPECIAL;
                        end
                        drive_vector(op, random_field());
                end
                report_test("random", N_RANDOM);

                $display("checks %0d, errors %0d", check_count, error_count);
                if (error_count == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* mips_ctrl.f */
+incdir+source
source/isa_pkg.sv
source/ctrl_pkg.sv
source/inst_classifier.sv
source/exec_ctrl_decoder.sv
source/memwb_ctrl_decoder.sv
source/ctrl_decoder.sv
tb/ctrl_decoder_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the control decoder testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f mips_ctrl.f --top-module ctrl_decoder_tb \
        --Mdir "$build_dir" -o ctrl_decoder_tb
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

"./$build_dir/ctrl_decoder_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
        echo "Simulation exited with status $sim_status"
        exit 1
fi

# The log decides the result.
if grep -qx "Verification passed" "$log_file"; then
        exit 0
else
        exit 1
fi
